// ==== cpc_mem_sys.f ====
+incdir+hdl
hdl/cpc_mem_pkg.sv
hdl/rom_boot_loader.sv
hdl/mem_arbiter.sv
hdl/shared_mem.sv
hdl/cpu_bus_ctrl.sv
hdl/mf2_unit.sv
hdl/cpc_mem_sys.sv
verif/tb_clock_gen.sv
verif/cpc_mem_sys_props.sv
verif/tb_cpc_mem_sys.sv

// ==== hdl/cpc_mem_params.svh ====
`ifndef CPC_MEM_PARAMS_SVH
`define CPC_MEM_PARAMS_SVH

// ----------------------------------------
// Shared memory geometry
// ----------------------------------------
`define MEM_PAGES      8         // 16 KB pages
`define PAGE_BYTES     16384
`define PAGE_W         3         // Page number width
`define MEM_ADDR_W     17        // 128 KB byte address

// ROM pages inside shared memory
`define PAGE_OS        3'd0
`define PAGE_MF2       3'd1
`define PAGE_BASIC     3'd2
`define PAGE_AMSDOS    3'd3
`define PAGE_RAM_BASE  3'd4      // CPU RAM in pages 4..7

`define AMSDOS_SLOT    8'd7      // Upper ROM number of AMSDOS

// ----------------------------------------
// Multiface Two
// ----------------------------------------
`define MF2_ROM_WIN    3'b000    // paddr[15:13], 0x0000-0x1FFF
`define MF2_RAM_WIN    3'b001    // paddr[15:13], 0x2000-0x3FFF
`define MF2_NMI_ADDR   16'h0066  // Z80 NMI vector
`define MF2_HIDE_ADDR  16'h0065
`define MF2_ON_PORT    16'hFEE8
`define MF2_OFF_PORT   16'hFEEA

`endif

// ==== hdl/cpc_mem_pkg.sv ====
`include "cpc_mem_params.svh"

package cpc_mem_pkg;

    // CPU cycle kinds
    typedef enum logic [1:0] {
        CYC_MEM   = 2'd0,
        CYC_IO    = 2'd1,
        CYC_FETCH = 2'd2      // Opcode fetch, M1
    } cpu_cycle_e;

    typedef enum logic [1:0] {
        BUS_IDLE     = 2'd0,
        BUS_WAIT_GNT = 2'd1,
        BUS_DATA     = 2'd2
    } bus_state_e;

    // Firmware file blocks, file address bits 15..14
    typedef enum logic [1:0] {
        BLK_OS     = 2'd0,
        BLK_BASIC  = 2'd1,
        BLK_AMSDOS = 2'd2,
        BLK_MF2    = 2'd3
    } rom_block_e;

    // ----------------------------------------
    // Port bundles
    // ----------------------------------------
    typedef struct packed {
        logic                   download;   // Level, high during a file
        logic                   wr;         // Byte strobe
        logic [7:0]             index;
        logic [`MEM_ADDR_W-1:0] addr;       // File address
        logic [7:0]             data;
    } load_t;

    typedef struct packed {
        logic       psel;
        logic       penable;
        logic       pwrite;
        logic [15:0] paddr;
        logic [7:0] pwdata;
        cpu_cycle_e kind;
    } cpu_req_t;

    typedef struct packed {
        logic       pready;
        logic [7:0] prdata;
    } cpu_rsp_t;

    typedef struct packed {
        logic                   req;
        logic                   we;
        logic [`MEM_ADDR_W-1:0] addr;
        logic [7:0]             wdata;
    } mem_req_t;

    typedef struct packed {
        logic       gnt;      // Same cycle as req
        logic       rvalid;   // One cycle after gnt
        logic [7:0] rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic       valid;
        cpu_cycle_e kind;
        logic [15:0] addr;
        logic [7:0] data;
    } cpu_event_t;

    typedef struct packed {
        logic        req;
        logic        we;
        logic [12:0] addr;    // 8 KB MF2 RAM
        logic [7:0]  wdata;
    } mf2_ram_req_t;

endpackage

// ==== hdl/cpc_mem_sys.sv ====
`timescale 1ns/10ps

module cpc_mem_sys
    import cpc_mem_pkg::*;
(
    input  logic     clk_48,
    input  logic     RESET,
    input  load_t    load,
    input  cpu_req_t cpu_req,
    output cpu_rsp_t cpu_rsp,
    input  logic     nmi_button,
    output logic     boot_done,
    output logic     mf2_en,
    output logic     mf2_nmi
);

    mem_req_t     boot_mem_req;
    mem_rsp_t     boot_mem_rsp;
    mem_req_t     cpu_mem_req;
    mem_rsp_t     cpu_mem_rsp;
    mem_req_t     mem_req;
    logic [7:0]   mem_rdata;
    mf2_ram_req_t mf2_req;
    logic [7:0]   mf2_rdata;
    cpu_event_t   cpu_event;

    rom_boot_loader i_boot (
        .clk_48(clk_48), .RESET(RESET), .load(load),
        .mem_req(boot_mem_req), .mem_rsp(boot_mem_rsp), .boot_done(boot_done)
    );

    mem_arbiter i_arb (
        .clk_48(clk_48), .RESET(RESET),
        .boot_req(boot_mem_req), .boot_rsp(boot_mem_rsp),
        .cpu_req(cpu_mem_req), .cpu_rsp(cpu_mem_rsp),
        .mem_req(mem_req), .mem_rdata(mem_rdata)
    );

    shared_mem i_mem (.clk_48(clk_48), .mem_req(mem_req), .mem_rdata(mem_rdata));

    cpu_bus_ctrl i_bus (
        .clk_48(clk_48), .RESET(RESET), .cpu_req(cpu_req), .cpu_rsp(cpu_rsp),
        .mem_req(cpu_mem_req), .mem_rsp(cpu_mem_rsp), .mf2_en(mf2_en),
        .mf2_req(mf2_req), .mf2_rdata(mf2_rdata), .cpu_event(cpu_event)
    );

    mf2_unit i_mf2 (
        .clk_48(clk_48), .RESET(RESET), .nmi_button(nmi_button), .cpu_event(cpu_event),
        .mf2_req(mf2_req), .mf2_rdata(mf2_rdata), .mf2_en(mf2_en), .mf2_nmi(mf2_nmi)
    );

endmodule

// ==== hdl/cpu_bus_ctrl.sv ====
`timescale 1ns/10ps
`include "cpc_mem_params.svh"

module cpu_bus_ctrl
    import cpc_mem_pkg::*;
(
    input  logic         clk_48,
    input  logic         RESET,
    input  cpu_req_t     cpu_req,
    output cpu_rsp_t     cpu_rsp,
    output mem_req_t     mem_req,
    input  mem_rsp_t     mem_rsp,
    input  logic         mf2_en,
    output mf2_ram_req_t mf2_req,
    input  logic [7:0]   mf2_rdata,
    output cpu_event_t   cpu_event
);

    bus_state_e         state;
    bus_state_e         state_nxt;
    logic               setup;       // APB setup phase
    logic               is_io;
    logic               is_read;
    logic               mem_tgt;     // Goes to shared memory
    logic               mf2_tgt;     // Goes to MF2 RAM
    logic [`PAGE_W-1:0] mem_page;
    logic [7:0]         upper_rom;
    logic               pready;
    logic [7:0]         prdata;

    assign setup   = cpu_req.psel & ~cpu_req.penable;
    assign is_io   = (cpu_req.kind == CYC_IO);
    assign is_read = ~cpu_req.pwrite;

    // ----------------------------------------
    // Address decode
    // ----------------------------------------
    always_comb begin
        mem_tgt  = 1'b0;
        mf2_tgt  = 1'b0;
        mem_page = `PAGE_RAM_BASE + {1'b0, cpu_req.paddr[15:14]};   // 0x10000 + paddr
        if (!is_io) begin
            if (mf2_en && cpu_req.paddr[15:13] == `MF2_ROM_WIN) begin
                mem_tgt  = is_read;          // ROM writes dropped
                mem_page = `PAGE_MF2;
            end else if (mf2_en && cpu_req.paddr[15:13] == `MF2_RAM_WIN) begin
                mf2_tgt = 1'b1;
            end else begin
                mem_tgt = 1'b1;
                if (is_read && cpu_req.paddr[15:14] == 2'b00)
                    mem_page = `PAGE_OS;     // Lower ROM
                else if (is_read && cpu_req.paddr[15:14] == 2'b11)
                    mem_page = (upper_rom == `AMSDOS_SLOT) ? `PAGE_AMSDOS : `PAGE_BASIC;
            end
        end
    end

    // ----------------------------------------
    // Bus FSM
    // ----------------------------------------
    always_comb begin
        state_nxt = state;
        unique case (state)
            BUS_IDLE:     if (setup) state_nxt = (mem_tgt & ~mem_rsp.gnt) ? BUS_WAIT_GNT : BUS_DATA;
            BUS_WAIT_GNT: if (mem_rsp.gnt) state_nxt = BUS_DATA;
            BUS_DATA:     if (pready) state_nxt = BUS_IDLE;
            default:      state_nxt = BUS_IDLE;
        endcase
    end

    always_ff @(posedge clk_48) begin
        if (RESET) begin
            state     <= BUS_IDLE;
            upper_rom <= 8'd0;
        end else begin
            state <= state_nxt;
            if (pready & is_io & cpu_req.pwrite & cpu_req.paddr[15:8] == 8'hDF)
                upper_rom <= cpu_req.pwdata;   // ROM select port
        end
    end

    // Memory request from setup until grant
    assign mem_req = '{req:   mem_tgt & ((state == BUS_IDLE & setup) | state == BUS_WAIT_GNT),
                       we:    cpu_req.pwrite,
                       addr:  {mem_page, cpu_req.paddr[13:0]},
                       wdata: cpu_req.pwdata};

    // MF2 RAM issued in setup, data back in first access cycle
    assign mf2_req = '{req:   mf2_tgt & setup & (state == BUS_IDLE),
                       we:    cpu_req.pwrite,
                       addr:  cpu_req.paddr[12:0],
                       wdata: cpu_req.pwdata};

    assign pready = (state == BUS_DATA) & cpu_req.psel & cpu_req.penable
                  & (~mem_tgt | mem_rsp.rvalid);

    always_comb begin
        if (is_io)
            prdata = 8'hFF;           // Nothing answers I/O reads
        else if (mf2_tgt)
            prdata = mf2_rdata;
        else
            prdata = mem_rsp.rdata;
    end

    assign cpu_rsp = '{pready: pready, prdata: prdata};

    // Completed I/O writes and fetches to the MF2 unit
    assign cpu_event = '{valid: pready & ((is_io & cpu_req.pwrite) | cpu_req.kind == CYC_FETCH),
                         kind:  cpu_req.kind,
                         addr:  cpu_req.paddr,
                         data:  cpu_req.pwdata};

endmodule

// ==== hdl/mem_arbiter.sv ====
`timescale 1ns/10ps

module mem_arbiter
    import cpc_mem_pkg::*;
(
    input  logic       clk_48,
    input  logic       RESET,
    input  mem_req_t   boot_req,
    output mem_rsp_t   boot_rsp,
    input  mem_req_t   cpu_req,
    output mem_rsp_t   cpu_rsp,
    output mem_req_t   mem_req,
    input  logic [7:0] mem_rdata
);

    logic boot_gnt;
    logic cpu_gnt;
    logic boot_vld_q;   // Read data owner, one cycle after grant
    logic cpu_vld_q;

    // Fixed priority, loader first
    assign boot_gnt = boot_req.req;
    assign cpu_gnt  = cpu_req.req & ~boot_req.req;

    assign mem_req = boot_gnt ? boot_req : cpu_req;   // cpu_req.req low when idle

    always_ff @(posedge clk_48) begin
        if (RESET) begin
            boot_vld_q <= 1'b0;
            cpu_vld_q  <= 1'b0;
        end else begin
            boot_vld_q <= boot_gnt;
            cpu_vld_q  <= cpu_gnt;
        end
    end

    assign boot_rsp = '{gnt: boot_gnt, rvalid: boot_vld_q, rdata: mem_rdata};
    assign cpu_rsp  = '{gnt: cpu_gnt, rvalid: cpu_vld_q, rdata: mem_rdata};

endmodule

// ==== hdl/mf2_unit.sv ====
`timescale 1ns/10ps
`include "cpc_mem_params.svh"

module mf2_unit
    import cpc_mem_pkg::*;
(
    input  logic         clk_48,
    input  logic         RESET,
    input  logic         nmi_button,
    input  cpu_event_t   cpu_event,
    input  mf2_ram_req_t mf2_req,
    output logic [7:0]   mf2_rdata,
    output logic         mf2_en,
    output logic         mf2_nmi
);

    logic        old_nmi_button;
    logic        mf2_hidden;
    logic        io_wr;
    logic        fetch;
    logic        port_ctrl;      // FEE8 / FEEA
    logic        shadow_we;
    logic [12:0] store_addr;
    logic [4:0]  pen_index;
    logic [3:0]  crtc_reg;
    logic        ram_we;
    logic [12:0] ram_addr;
    logic [7:0]  ram_wdata;
    logic [7:0]  ram [8192];     // Private 8 KB RAM

    assign io_wr     = cpu_event.valid & (cpu_event.kind == CYC_IO);
    assign fetch     = cpu_event.valid & (cpu_event.kind == CYC_FETCH);
    assign port_ctrl = (cpu_event.addr == `MF2_ON_PORT) | (cpu_event.addr == `MF2_OFF_PORT);

    // ----------------------------------------
    // Hardware register shadow table
    // ----------------------------------------
    always_comb begin
        casez ({cpu_event.addr[15:8], cpu_event.data[7:6]})
            {8'h7F, 2'b00}: store_addr = 13'h1FCF;                            // Pen select
            {8'h7F, 2'b01}: store_addr = pen_index[4] ? 13'h1FDF : {9'h1F9, pen_index[3:0]};
            {8'h7F, 2'b10}: store_addr = 13'h1FEF;                            // Mode, ROM enables
            {8'h7F, 2'b11}: store_addr = 13'h1FFF;                            // RAM banking
            {8'hBC, 2'b??}: store_addr = 13'h1CFF;                            // CRTC select
            {8'hBD, 2'b??}: store_addr = {9'h1DB, crtc_reg};                  // CRTC data
            {8'hF7, 2'b??}: store_addr = 13'h17FF;                            // PPI control
            {8'hDF, 2'b??}: store_addr = 13'h1AAC;                            // Upper ROM
            default:        store_addr = 13'h0000;
        endcase
    end

    assign shadow_we = io_wr & ~port_ctrl & (|store_addr);

    always_ff @(posedge clk_48) begin
        if (shadow_we && cpu_event.addr[15:8] == 8'h7F && cpu_event.data[7:6] == 2'b00)
            pen_index <= cpu_event.data[4:0];
        if (shadow_we && cpu_event.addr[15:8] == 8'hBC)
            crtc_reg <= cpu_event.data[3:0];
    end

    // RAM port, shadow write first
    assign ram_we    = shadow_we | (mf2_req.req & mf2_req.we);
    assign ram_addr  = shadow_we ? store_addr : mf2_req.addr;
    assign ram_wdata = shadow_we ? cpu_event.data : mf2_req.wdata;

    always_ff @(posedge clk_48) begin
        if (ram_we)
            ram[ram_addr] <= ram_wdata;
        mf2_rdata <= ram[ram_addr];
    end

    // ----------------------------------------
    // NMI, enable and hide
    // ----------------------------------------
    always_ff @(posedge clk_48) begin
        if (RESET) begin
            old_nmi_button <= 1'b0;
            mf2_nmi        <= 1'b0;
            mf2_en         <= 1'b0;
            mf2_hidden     <= 1'b0;
        end else begin
            old_nmi_button <= nmi_button;
            if (nmi_button & ~old_nmi_button & ~mf2_en)
                mf2_nmi <= 1'b1;                // Button press
            if (fetch && cpu_event.addr == `MF2_NMI_ADDR && mf2_nmi) begin
                mf2_en     <= 1'b1;             // NMI taken, page in
                mf2_hidden <= 1'b0;
                mf2_nmi    <= 1'b0;
            end
            if (fetch && cpu_event.addr == `MF2_HIDE_ADDR && mf2_en)
                mf2_hidden <= 1'b1;
            if (io_wr && cpu_event.addr == `MF2_ON_PORT)
                mf2_en <= ~mf2_hidden;
            else if (io_wr && cpu_event.addr == `MF2_OFF_PORT)
                mf2_en <= 1'b0;
        end
    end

endmodule

// ==== hdl/rom_boot_loader.sv ====
`timescale 1ns/10ps
`include "cpc_mem_params.svh"

module rom_boot_loader
    import cpc_mem_pkg::*;
(
    input  logic     clk_48,
    input  logic     RESET,
    input  load_t    load,
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp,
    output logic     boot_done
);

    logic                   old_download;
    logic                   strobe_hit;
    rom_block_e             blk;
    logic [`PAGE_W-1:0]     blk_page;
    logic                   wr_pend;
    logic [`MEM_ADDR_W-1:0] wr_addr;
    logic [7:0]             wr_data;

    // Firmware is index 0, file above 0x10000 (664 set) dropped
    assign strobe_hit = load.download & load.wr & (load.index == 8'd0) & ~load.addr[16];

    assign blk = rom_block_e'(load.addr[15:14]);

    always_comb begin
        unique case (blk)
            BLK_OS:     blk_page = `PAGE_OS;
            BLK_BASIC:  blk_page = `PAGE_BASIC;
            BLK_AMSDOS: blk_page = `PAGE_AMSDOS;
            BLK_MF2:    blk_page = `PAGE_MF2;
            default:    blk_page = `PAGE_OS;
        endcase
    end

    // ----------------------------------------
    // Write request and boot status
    // ----------------------------------------
    always_ff @(posedge clk_48) begin
        if (RESET) begin
            old_download <= 1'b0;
            boot_done    <= 1'b0;
            wr_pend      <= 1'b0;
        end else begin
            old_download <= load.download;
            if (~old_download & load.download)
                boot_done <= 1'b0;              // New download starts
            else if (old_download & ~load.download)
                boot_done <= 1'b1;
            if (strobe_hit)
                wr_pend <= 1'b1;
            else if (mem_rsp.gnt)
                wr_pend <= 1'b0;                // Byte accepted
        end
    end

    always_ff @(posedge clk_48) begin
        if (strobe_hit) begin
            wr_addr <= {blk_page, load.addr[13:0]};
            wr_data <= load.data;
        end
    end

    assign mem_req = '{req: wr_pend, we: 1'b1, addr: wr_addr, wdata: wr_data};

endmodule

// ==== hdl/shared_mem.sv ====
`timescale 1ns/10ps
`include "cpc_mem_params.svh"

module shared_mem
    import cpc_mem_pkg::*;
(
    input  logic       clk_48,
    input  mem_req_t   mem_req,
    output logic [7:0] mem_rdata
);

    localparam int unsigned DEPTH = `MEM_PAGES * `PAGE_BYTES;

    logic [7:0] mem [DEPTH];   // ROM pages 0..3, RAM 4..7

    always_ff @(posedge clk_48) begin
        if (mem_req.req & mem_req.we)
            mem[mem_req.addr] <= mem_req.wdata;
        mem_rdata <= mem[mem_req.addr];   // Old data on a write
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line in sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -j 0 --assert --top-module tb_cpc_mem_sys -f cpc_mem_sys.f \
    && ./obj_dir/Vtb_cpc_mem_sys > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "Verification passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== verif/cpc_mem_stim.txt ====
# op operand1 operand2 operand3, all hex
# L file_addr data | E | W addr data | R addr expected | I port data | F addr | N | C boot_done mf2_en mf2_nmi
C 0 0 0
L 00010 11
L 00100 33
L 04010 B1
L 08010 A5
L 0C005 F5
L 10010 EE
E
C 1 0 0
R 0010 11
R C010 B1
W 4123 5A
R 4123 5A
W 0100 77
R 0100 33
I DF00 07
R C010 A5
I DF00 00
R C010 B1
N
C 1 0 1
F 0066
C 1 1 0
R 0005 F5
W 2100 3C
R 2100 3C
I BC00 0C
I BD00 5E
I 7F00 03
R 3CFF 0C
R 3DBC 5E
R 3FCF 03
F 0065
I FEEA 00
C 1 0 0
I FEE8 00
C 1 0 0

// ==== verif/cpc_mem_sys_props.sv ====
`timescale 1ns/10ps

module cpc_mem_sys_props
    import cpc_mem_pkg::*;
(
    input logic       clk_48,
    input logic       RESET,
    input logic       boot_gnt,
    input logic       cpu_gnt,
    input cpu_req_t   cpu_req,
    input cpu_rsp_t   cpu_rsp,
    input cpu_event_t cpu_event,
    input logic       mf2_en,
    input logic       mf2_nmi
);

    logic fetch_evt;

    assign fetch_evt = cpu_event.valid && (cpu_event.kind == CYC_FETCH);

    // ----------------------------------------
    // Arbiter and APB rules
    // ----------------------------------------
    grant_excl: assert property (@(posedge clk_48) disable iff (RESET)
        !(boot_gnt && cpu_gnt))
        else $error("Both memory grants high");

    // Access phase must follow a cycle with psel already high
    pready_in_access: assert property (@(posedge clk_48) disable iff (RESET)
        $rose(cpu_rsp.pready) |->
            (cpu_req.psel && cpu_req.penable && $past(cpu_req.psel)))
        else $error("pready rose outside an access phase");

    // Address, data and kind frozen until pready
    req_stable: assert property (@(posedge clk_48) disable iff (RESET)
        (cpu_req.psel && !cpu_rsp.pready) |=>
            (cpu_req.psel && $stable({cpu_req.paddr, cpu_req.pwrite,
                                      cpu_req.pwdata, cpu_req.kind})))
        else $error("APB request changed before pready");

    // ----------------------------------------
    // MF2 paging
    // ----------------------------------------
    nmi_take_on_fetch: assert property (@(posedge clk_48) disable iff (RESET)
        ($rose(mf2_en) && $fell(mf2_nmi)) |-> $past(fetch_evt))
        else $error("MF2 paged in on NMI without a fetch");

endmodule

bind cpc_mem_sys cpc_mem_sys_props i_props (
    .clk_48(clk_48),
    .RESET(RESET),
    .boot_gnt(boot_mem_rsp.gnt),
    .cpu_gnt(cpu_mem_rsp.gnt),
    .cpu_req(cpu_req),
    .cpu_rsp(cpu_rsp),
    .cpu_event(cpu_event),
    .mf2_en(mf2_en),
    .mf2_nmi(mf2_nmi)
);

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk_48,
    output logic RESET
);

    initial begin
        clk_48 = 1'b0;
        forever #20 clk_48 = ~clk_48;   // 40 ns period
    end

    // Reset held for the first two edges
    initial begin
        RESET = 1'b1;
        repeat (2) @(posedge clk_48);
        RESET <= 1'b0;
    end

endmodule

// ==== verif/tb_cpc_mem_sys.sv ====
`timescale 1ns/10ps

module tb_cpc_mem_sys
    import cpc_mem_pkg::*;
();

    localparam int PREADY_TIMEOUT = 40;   // Cycles per APB access
    localparam int FLAG_TIMEOUT   = 20;
    localparam int RESET_TIMEOUT  = 10;

    logic     clk_48;
    logic     RESET;
    load_t    load;
    cpu_req_t cpu_req;
    cpu_rsp_t cpu_rsp;
    logic     nmi_button;
    logic     boot_done;
    logic     mf2_en;
    logic     mf2_nmi;
    int       errors;
    int       checks;

    tb_clock_gen i_clk (.clk_48(clk_48), .RESET(RESET));

    cpc_mem_sys i_dut (
        .clk_48(clk_48), .RESET(RESET), .load(load), .cpu_req(cpu_req), .cpu_rsp(cpu_rsp),
        .nmi_button(nmi_button), .boot_done(boot_done), .mf2_en(mf2_en), .mf2_nmi(mf2_nmi)
    );

    // ----------------------------------------
    // Bus drivers
    // ----------------------------------------
    task automatic apb_access(
        input  cpu_cycle_e  kind,
        input  logic        wr,
        input  logic [15:0] addr,
        input  logic [7:0]  wdata,
        output logic [7:0]  rdata,
        output logic        done
    );
        int cnt;
        cnt   = 0;
        done  = 1'b0;
        rdata = 8'h00;
        @(posedge clk_48);
        cpu_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr,
                     pwdata: wdata, kind: kind};          // Setup phase
        @(posedge clk_48);
        cpu_req.penable <= 1'b1;
        while (!done && cnt < PREADY_TIMEOUT) begin
            @(negedge clk_48);                           // pready settled here
            if (cpu_rsp.pready) begin
                done  = 1'b1;
                rdata = cpu_rsp.prdata;
            end
            cnt++;
        end
        @(posedge clk_48);
        cpu_req.psel    <= 1'b0;                         // Transfer ends on this edge
        cpu_req.penable <= 1'b0;
        if (!done) begin
            $display("Error at %0t: no pready within %0d cycles for access at 0x%h",
                     $time, PREADY_TIMEOUT, addr);
            errors++;
        end
    endtask

    // One download strobe, then enough idle cycles for the 4-cycle spacing
    task automatic load_byte(input logic [16:0] addr, input logic [7:0] data);
        @(posedge clk_48);
        load <= '{download: 1'b1, wr: 1'b1, index: 8'd0, addr: addr, data: data};
        @(posedge clk_48);
        load.wr <= 1'b0;
        repeat (3) @(posedge clk_48);
    endtask

    task automatic end_download();
        @(posedge clk_48);
        load.download <= 1'b0;
    endtask

    task automatic pulse_nmi();
        @(posedge clk_48);
        nmi_button <= 1'b1;
        repeat (2) @(posedge clk_48);
        nmi_button <= 1'b0;
    endtask

    // Waits for all three flags to match
    task automatic check_flags(input logic exp_boot, input logic exp_en, input logic exp_nmi);
        int   cnt;
        logic match;
        cnt   = 0;
        match = 1'b0;
        while (!match && cnt < FLAG_TIMEOUT) begin
            @(negedge clk_48);
            match = (boot_done === exp_boot) && (mf2_en === exp_en) && (mf2_nmi === exp_nmi);
            cnt++;
        end
        checks++;
        if (!match) begin
            $display("Fail at %0t: flags boot_done/mf2_en/mf2_nmi expected %b%b%b, got %b%b%b",
                     $time, exp_boot, exp_en, exp_nmi, boot_done, mf2_en, mf2_nmi);
            errors++;
        end
    endtask

    task automatic run_op(input byte op, input logic [31:0] a, input logic [31:0] b,
                          input logic [31:0] c);
        logic [7:0] rdata;
        logic       done;
        case (op)
            "L": load_byte(a[16:0], b[7:0]);
            "E": end_download();
            "W": apb_access(CYC_MEM, 1'b1, a[15:0], b[7:0], rdata, done);
            "R": begin
                apb_access(CYC_MEM, 1'b0, a[15:0], 8'h00, rdata, done);
                checks++;
                if (done && rdata !== b[7:0]) begin
                    $display("Fail at %0t: prdata at 0x%h expected 0x%h, got 0x%h",
                             $time, a[15:0], b[7:0], rdata);
                    errors++;
                end
            end
            "I": apb_access(CYC_IO, 1'b1, a[15:0], b[7:0], rdata, done);
            "F": apb_access(CYC_FETCH, 1'b0, a[15:0], 8'h00, rdata, done);   // M1 cycle
            "N": pulse_nmi();
            "C": check_flags(a[0], b[0], c[0]);
            default: begin
                $display("Error: unknown operation '%c' in stimulus file", op);
                errors++;
            end
        endcase
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        int          fd;
        int          n;
        int          cnt;
        string       line;
        byte         op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        errors     = 0;
        checks     = 0;
        load       = '0;
        cpu_req    = '0;
        nmi_button = 1'b0;
        cnt        = 0;
        while (RESET !== 1'b0 && cnt < RESET_TIMEOUT) begin
            @(posedge clk_48);
            cnt++;
        end
        if (RESET !== 1'b0) begin
            $display("Error: reset was never released");
            errors++;
        end
        fd = $fopen("verif/cpc_mem_stim.txt", "r");
        if (fd == 0) begin
            $display("Error: cannot open stimulus file verif/cpc_mem_stim.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n    = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin   // Skip comments
                    a = '0;
                    b = '0;
                    c = '0;
                    n = $sscanf(line, "%c %h %h %h", op, a, b, c);
                    run_op(op, a, b, c);
                end
            end
            $fclose(fd);
        end
        repeat (2) @(posedge clk_48);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
